// File: Bender.yml
package:
  name: singlecpu

sources:
  - design/cpuPkg.sv
  - design/instMem.sv
  - design/regFile.sv
  - design/decoder.sv
  - design/alu.sv
  - design/dataMem.sv
  - design/singleCpu.sv
  - target: simulation
    files:
      - testbench/tbSingleCpu.sv

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::XLEN-1:0] a,
    input  logic [cpuPkg::XLEN-1:0] b,
    input  cpuPkg::aluOpT           op,
    output logic [cpuPkg::XLEN-1:0] y,
    output logic                    zero
);
    import cpuPkg::*;

    logic sameOps;
    logic ltSigned;

    assign sameOps  = (a == b);
    assign ltSigned = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_SLT: y = {{(XLEN-1){1'b0}}, ltSigned};
            default: y = a + b;
        endcase
    end

    // Branch compare takes the equality path instead of waiting on the subtractor
    assign zero = ((op == ALU_SUB) || (op == ALU_XOR)) ? sameOps : (y == '0);

    // Operands are unknown until the first program word and registers settle
    zeroMatchesResult: assert final ($isunknown({a, b}) || (zero == (y == '0)))
        else $error("alu: zero flag disagrees with result");

endmodule

// File: design/cpuPkg.sv
package cpuPkg;

    // Datapath and memory geometry
    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int NUM_REGS   = 1 << REG_AW;
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS); // 8
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS); // 8

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcodeT;

    // Encoded as {inst[30], funct3}, same layout as the R-type fields
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b1000,
        ALU_SLT = 4'b0010,
        ALU_XOR = 4'b0100,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111
    } aluOpT;

    // Main control bundle, 9 bits
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // 1 selects the immediate as ALU operand b
        logic  memWrite;
        logic  memToReg; // 1 selects load data for writeback
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    // Register file write port, 38 bits
    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wbT;

    // Data memory write, 65 bits
    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } storeT;

endpackage

// File: design/dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic                    CLK,
    input  cpuPkg::storeT           st,
    input  logic [cpuPkg::XLEN-1:0] raddr,
    output logic [cpuPkg::XLEN-1:0] rdata
);
    import cpuPkg::*;

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] wrIdx;
    logic [DMEM_AW-1:0] rdIdx;

    assign wrIdx = st.addr[DMEM_AW+1:2];
    assign rdIdx = raddr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (st.en) begin
            mem[wrIdx] <= st.data;
        end
    end

    assign rdata = mem[rdIdx]; // Read is combinational

    // Only word accesses exist, so a misaligned store means a bad base register
    storeAligned: assert property (@(posedge CLK) st.en |-> (st.addr[1:0] == 2'b00))
        else $error("dataMem: misaligned store to %h", st.addr);

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [cpuPkg::XLEN-1:0]   inst,
    output cpuPkg::ctrlT              ctrl,
    output logic [cpuPkg::XLEN-1:0]   imm,
    output logic [cpuPkg::REG_AW-1:0] rs1,
    output logic [cpuPkg::REG_AW-1:0] rs2,
    output logic [cpuPkg::REG_AW-1:0] rd
);
    import cpuPkg::*;

    opcodeT          opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;

    // funct3 to ALU operation, subSel only honored for R-type
    function automatic aluOpT arithOp(input logic [2:0] f3, input logic subSel);
        aluOpT op;
        case (f3)
            3'b000:  op = subSel ? ALU_SUB : ALU_ADD;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // Sign-extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        ctrl = '0; // Unknown opcodes fall out as no-ops
        imm  = '0;
        case (opcode)
            OP_R: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = arithOp(funct3, inst[30]);
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = arithOp(funct3, 1'b0);
                imm           = immI;
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluOp    = ALU_ADD; // Base plus offset
                imm           = immI;
            end
            OP_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = ALU_ADD;
                imm           = immS;
            end
            OP_BRANCH: begin
                // Only beq is supported
                if (funct3 == 3'b000) begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = ALU_SUB;
                    imm         = immB; // Already scaled by 2
                end
            end
            default: ;
        endcase
    end

endmodule

// File: design/instMem.sv
`timescale 1ns/1ps

module instMem (
    input  logic                       CLK,
    input  logic                       rstN,
    input  logic                       progWe,
    input  logic [cpuPkg::IMEM_AW-1:0] progAddr,
    input  logic [cpuPkg::XLEN-1:0]    progData,
    input  logic [cpuPkg::XLEN-1:0]    addr,
    output logic [cpuPkg::XLEN-1:0]    inst
);
    import cpuPkg::*;

    logic [XLEN-1:0] mem [IMEM_WORDS];
    logic [IMEM_AW-1:0] wordIdx;

    // Byte address to word index, low two bits dropped
    assign wordIdx = addr[IMEM_AW+1:2];

    // Program load only while the core is held in reset
    always_ff @(posedge CLK) begin
        if (!rstN && progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign inst = mem[wordIdx]; // Combinational fetch

    // A program write outside reset would be dropped silently
    noLoadWhileRunning: assert property (@(posedge CLK) rstN |-> !progWe)
        else $error("instMem: progWe asserted while rstN is high");

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                      CLK,
    input  logic                      rstN,
    input  logic [cpuPkg::REG_AW-1:0] rs1,
    input  logic [cpuPkg::REG_AW-1:0] rs2,
    input  cpuPkg::wbT                wb,
    output logic [cpuPkg::XLEN-1:0]   rd1,
    output logic [cpuPkg::XLEN-1:0]   rd2
);
    import cpuPkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data; // x0 writes dropped
        end
    end

    // Asynchronous reads, x0 always reads zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/singleCpu.sv
`timescale 1ns/1ps

module singleCpu (
    input  logic                       CLK,
    input  logic                       rstN,
    input  logic                       progWe,
    input  logic [cpuPkg::IMEM_AW-1:0] progAddr,
    input  logic [cpuPkg::XLEN-1:0]    progData,
    output logic [cpuPkg::XLEN-1:0]    inst,
    output logic [cpuPkg::XLEN-1:0]    pc,
    output cpuPkg::wbT                 wb,
    output cpuPkg::storeT              st
);
    import cpuPkg::*;

    ctrlT              ctrl;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rd1;
    logic [XLEN-1:0]   rd2;
    logic [XLEN-1:0]   aluB;
    logic [XLEN-1:0]   aluY;
    logic              aluZero;
    logic [XLEN-1:0]   memData;
    logic [XLEN-1:0]   pcPlus4;
    logic [XLEN-1:0]   pcBranch;
    logic              takeBranch;
    logic [XLEN-1:0]   nextPc;

    // Next PC selection
    assign pcPlus4    = pc + 32'd4;
    assign pcBranch   = pc + imm;
    assign takeBranch = ctrl.branch & aluZero;
    assign nextPc     = takeBranch ? pcBranch : pcPlus4;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    instMem uInstMem (
        .CLK      (CLK),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .addr     (pc),
        .inst     (inst)
    );

    decoder uDecoder (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd)
    );

    regFile uRegFile (
        .CLK  (CLK),
        .rstN (rstN),
        .rs1  (rs1),
        .rs2  (rs2),
        .wb   (wb),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    assign aluB = ctrl.aluSrc ? imm : rd2; // Operand b mux

    alu uAlu (
        .a    (rd1),
        .b    (aluB),
        .op   (ctrl.aluOp),
        .y    (aluY),
        .zero (aluZero)
    );

    dataMem uDataMem (
        .CLK   (CLK),
        .st    (st),
        .raddr (aluY),
        .rdata (memData)
    );

    // Writeback and store bundles, strobes held off during reset
    always_comb begin
        wb.en   = rstN & ctrl.regWrite;
        wb.addr = rd;
        wb.data = ctrl.memToReg ? memData : aluY;
        st.en   = rstN & ctrl.memWrite;
        st.addr = aluY;
        st.data = rd2;
    end

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("singleCpu: PC %h not word-aligned", pc);

endmodule

// File: project.f
design/cpuPkg.sv
design/instMem.sv
design/regFile.sv
design/decoder.sv
design/alu.sv
design/dataMem.sv
design/singleCpu.sv
testbench/tbSingleCpu.sv

// File: testbench/tbSingleCpu.sv
`timescale 1ns/1ps

module tbSingleCpu;
    import cpuPkg::*;

    // Expected view of one retired instruction
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        wbT              wb;
        storeT           st;
    } expT;

    logic                CLK = 1'b0;
    logic                rstN;
    logic                progWe;
    logic [IMEM_AW-1:0]  progAddr;
    logic [XLEN-1:0]     progData;
    logic [XLEN-1:0]     inst;
    logic [XLEN-1:0]     pc;
    wbT                  wb;
    storeT               st;

    // ISA model state
    logic [XLEN-1:0] progMem [IMEM_WORDS];
    logic [XLEN-1:0] refRegs [32];
    logic [XLEN-1:0] refMem [DMEM_WORDS];
    logic [XLEN-1:0] refPc;
    expT             expNow;

    logic [XLEN-1:0] prog [$];
    string           curTest;
    int              errCount;
    int              passCount;
    int              failCount;
    int              rstCycles;
    logic [XLEN-1:0] rndWord;
    logic [XLEN-1:0] base;
    int              loopCount;

    singleCpu dut (
        .CLK      (CLK),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .inst     (inst),
        .pc       (pc),
        .wb       (wb),
        .st       (st)
    );

    always #10 CLK = ~CLK; // 20 ns period

    // Instruction encoders
    function automatic logic [31:0] rType(input logic [2:0] f3, input bit isSub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {isSub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
    endfunction

    // Integer ops by funct3 as the ISA defines them
    function automatic logic [31:0] arith(input logic [2:0] f3, input bit isSub,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // One instruction of the ISA model, updates model state
    function automatic expT refStep();
        expT         e;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] addr;
        logic [31:0] nextPc;
        ins  = progMem[refPc[IMEM_AW+1:2]];
        a    = refRegs[ins[19:15]];
        b    = refRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        e = '0;
        e.pc    = refPc;
        e.inst  = ins;
        nextPc  = refPc + 32'd4;
        e.wb.addr = ins[11:7];
        case (ins[6:0])
            7'b0110011: begin
                e.wb.en   = 1'b1;
                e.wb.data = arith(ins[14:12], ins[30], a, b);
            end
            7'b0010011: begin
                e.wb.en   = 1'b1;
                e.wb.data = arith(ins[14:12], 1'b0, a, immI);
            end
            7'b0000011: begin
                addr      = a + immI;
                e.wb.en   = 1'b1;
                e.wb.data = refMem[addr[DMEM_AW+1:2]];
            end
            7'b0100011: begin
                addr      = a + immS;
                e.st.en   = 1'b1;
                e.st.addr = addr;
                e.st.data = b;
                refMem[addr[DMEM_AW+1:2]] = b;
            end
            7'b1100011: begin
                if (ins[14:12] == 3'b000 && a == b) begin
                    nextPc = refPc + immB;
                end
            end
            default: ; // Anything else retires as a no-op
        endcase
        if (e.wb.en && e.wb.addr != 5'd0) begin
            refRegs[e.wb.addr] = e.wb.data;
        end
        refPc = nextPc;
        return e;
    endfunction

    task automatic checkVal(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            errCount++;
            $display("Error: test %s, %s expected %h actual %h", curTest, what, expVal, actVal);
        end
    endtask

    // Mid-cycle compare, all DUT outputs settled
    always @(negedge CLK) begin
        if (!rstN) begin
            if (rstCycles > 0) begin
                checkVal("pc during reset", 32'd0, pc);
            end
            checkVal("wb.en during reset", 32'd0, wb.en);
            checkVal("st.en during reset", 32'd0, st.en);
            rstCycles++;
            for (int i = 0; i < 32; i++) begin
                refRegs[i] = '0;
            end
            refPc = '0;
        end else begin
            rstCycles = 0;
            expNow = refStep();
            checkVal("pc", expNow.pc, pc);
            checkVal("inst", expNow.inst, inst);
            checkVal("wb.en", expNow.wb.en, wb.en);
            if (expNow.wb.en) begin
                checkVal("wb.addr", expNow.wb.addr, wb.addr);
                checkVal("wb.data", expNow.wb.data, wb.data);
            end
            checkVal("st.en", expNow.st.en, st.en);
            if (expNow.st.en) begin
                checkVal("st.addr", expNow.st.addr, st.addr);
                checkVal("st.data", expNow.st.data, st.data);
            end
        end
    end

    // Load prog during 16 reset cycles, run to the self-loop, leave reset asserted
    task automatic runTest(input string name);
        int startErr;
        int cycles;
        bit done;
        curTest  = name;
        startErr = errCount;
        for (int i = 0; i < 16; i++) begin
            progWe = (i < prog.size());
            if (i < prog.size()) begin
                progAddr   = i[IMEM_AW-1:0];
                progData   = prog[i];
                progMem[i] = prog[i];
            end
            @(posedge CLK);
            #1;
        end
        progWe = 1'b0;
        rstN   = 1'b1;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < 2000) begin
            @(negedge CLK);
            cycles++;
            if (inst === bType(5'd0, 5'd0, 13'd0)) begin
                done = 1'b1;
            end
        end
        @(posedge CLK);
        #1;
        rstN = 1'b0;
        if (!done) begin
            failCount++;
            $display("Test %s: never reached its closing loop within 2000 cycles", name);
        end else if (errCount != startErr) begin
            failCount++;
            $display("Test %s: FAILED with %0d mismatches", name, errCount - startErr);
        end else begin
            passCount++;
            $display("Test %s: ok after %0d cycles", name, cycles);
        end
        prog.delete();
    endtask

    initial begin
        void'($urandom(79));
        rstN      = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        errCount  = 0;
        passCount = 0;
        failCount = 0;
        rstCycles = 0;
        refPc     = '0;
        @(posedge CLK);
        #1;

        prog.push_back(iType(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd2, 5'd1, -12'sd3));
        prog.push_back(rType(3'b000, 1'b0, 5'd3, 5'd1, 5'd2));
        prog.push_back(bType(5'd0, 5'd0, 13'd0));
        runTest("reset_pc");

        prog.push_back(iType(OP_IMM, 3'b000, 5'd1, 5'd0, $urandom()));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd2, 5'd0, $urandom()));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd3, 5'd0, $urandom()));
        prog.push_back(rType(3'b000, 1'b0, 5'd4, 5'd1, 5'd2)); // add
        prog.push_back(rType(3'b000, 1'b1, 5'd5, 5'd1, 5'd2)); // sub
        prog.push_back(rType(3'b111, 1'b0, 5'd6, 5'd1, 5'd3));
        prog.push_back(rType(3'b110, 1'b0, 5'd7, 5'd2, 5'd3));
        prog.push_back(rType(3'b100, 1'b0, 5'd8, 5'd1, 5'd2));
        prog.push_back(rType(3'b010, 1'b0, 5'd9, 5'd1, 5'd2)); // Signed slt both ways
        prog.push_back(rType(3'b010, 1'b0, 5'd10, 5'd2, 5'd1));
        prog.push_back(iType(OP_IMM, 3'b111, 5'd11, 5'd1, $urandom()));
        prog.push_back(iType(OP_IMM, 3'b110, 5'd12, 5'd2, $urandom()));
        prog.push_back(bType(5'd0, 5'd0, 13'd0));
        runTest("alu_ops");

        prog.push_back(iType(OP_IMM, 3'b000, 5'd0, 5'd0, $urandom())); // Write to x0
        prog.push_back(iType(OP_IMM, 3'b000, 5'd1, 5'd0, $urandom()));
        prog.push_back(rType(3'b000, 1'b0, 5'd0, 5'd1, 5'd1));
        prog.push_back(rType(3'b000, 1'b0, 5'd2, 5'd0, 5'd1));
        prog.push_back(rType(3'b110, 1'b0, 5'd3, 5'd0, 5'd0));
        prog.push_back(rType(3'b000, 1'b1, 5'd4, 5'd1, 5'd0));
        prog.push_back(bType(5'd0, 5'd0, 13'd0));
        runTest("x0_writes");

        base = ($urandom() % 200) * 4; // Word aligned, inside data memory
        prog.push_back(iType(OP_IMM, 3'b000, 5'd1, 5'd0, base[11:0]));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd2, 5'd0, $urandom()));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd3, 5'd0, $urandom()));
        prog.push_back(sType(5'd2, 5'd1, 12'd0));
        prog.push_back(sType(5'd3, 5'd1, 12'd4));
        prog.push_back(iType(OP_LOAD, 3'b010, 5'd4, 5'd1, 12'd0));
        prog.push_back(iType(OP_LOAD, 3'b010, 5'd5, 5'd1, 12'd4));
        prog.push_back(rType(3'b000, 1'b0, 5'd6, 5'd4, 5'd5));
        prog.push_back(bType(5'd0, 5'd0, 13'd0));
        runTest("load_store");

        loopCount = 1 + ($urandom() % 8);
        prog.push_back(iType(OP_IMM, 3'b000, 5'd1, 5'd0, loopCount[11:0]));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd2, 5'd0, 12'd0));
        prog.push_back(iType(OP_IMM, 3'b000, 5'd2, 5'd2, 12'd1)); // Loop body at 8
        prog.push_back(bType(5'd2, 5'd1, 13'd8));                  // Exit when count reached
        prog.push_back(bType(5'd0, 5'd0, -13'sd8));                // Back to body
        prog.push_back(bType(5'd1, 5'd0, 13'd8));                  // Falls through
        prog.push_back(iType(OP_IMM, 3'b000, 5'd3, 5'd0, 12'd1));
        prog.push_back(bType(5'd0, 5'd0, 13'd0));
        runTest("branches");

        rndWord = $urandom();
        prog.push_back(iType(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd9));
        prog.push_back(32'h12345037); // lui
        prog.push_back(32'h0000000F); // fence
        prog.push_back({rndWord[31:7], 7'b0001011});
        prog.push_back(iType(OP_IMM, 3'b000, 5'd2, 5'd1, 12'd1));
        prog.push_back(bType(5'd0, 5'd0, 13'd0));
        runTest("unknown_ops");

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
